/* source/bpu_macros.svh */
`ifndef BPU_MACROS_SVH
`define BPU_MACROS_SVH

// datapath widths
`define XLEN            32
`define HIST_W          16

// direction predictor
`define BIMODAL_ENTRIES 512     // indexed by pc[9:1]
`define TAGE_ENTRIES    256     // per tagged table
`define TAG_W           10
`define PARTIAL_TAG_W   6       // upper tag bits compared on lookup

// target buffer, index pc[9:2], tag pc[31:10]
`define BTB_ENTRIES     256
`define BTB_TAG_W       22

// return stack
`define RAS_DEPTH       32
`define RAS_PTR_W       6       // one spare bit so full is representable

// rv32i control transfer opcodes
`define OPC_BRANCH      7'b1100011
`define OPC_JAL         7'b1101111
`define OPC_JALR        7'b1100111

`endif

/* source/bpu_pkg.sv */
`default_nettype none

package bpu_pkg;

    // B-type view, conditional branches
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_t;

    // J-type view, jal
    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_t;

    // I-type view, jalr and return detection
    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_t;

    typedef union packed {
        b_t b;
        j_t j;
        i_t i;
    } inst_u;

    // which table supplied the direction
    typedef enum logic [1:0] {
        PROV_BIMODAL = 2'd0,
        PROV_T0      = 2'd1,
        PROV_T1      = 2'd2
    } provider_e;

endpackage

`default_nettype wire

/* source/bpu_decode_select.sv */
`timescale 1ns/1ps
`default_nettype none
`include "bpu_macros.svh"

module bpu_decode_select (
    input  wire [`XLEN-1:0]         pc_i,
    input  wire bpu_pkg::inst_u     inst_i,
    input  wire                     dir_taken_i,
    input  wire bpu_pkg::provider_e dir_provider_i,
    input  wire                     btb_hit_i,
    input  wire [`XLEN-1:0]         btb_target_i,
    input  wire                     ras_empty_i,
    input  wire [`XLEN-1:0]         ras_top_i,
    output logic                    branch_o,
    output logic                    pred_taken_o,
    output logic [`XLEN-1:0]        pred_pc_o,
    output bpu_pkg::provider_e      provider_o
);

    logic             is_branch;
    logic             is_jal;
    logic             is_jalr;
    logic             is_ret;
    logic [`XLEN-1:0] b_imm;
    logic [`XLEN-1:0] j_imm;
    logic [`XLEN-1:0] pc_plus4;

    assign is_branch = (inst_i.b.opcode == `OPC_BRANCH);
    assign is_jal    = (inst_i.j.opcode == `OPC_JAL);
    assign is_jalr   = (inst_i.i.opcode == `OPC_JALR);

    // jalr x0, 0(ra) or 0(t0)
    assign is_ret = is_jalr && (inst_i.i.rd == 5'd0) && (inst_i.i.imm12 == 12'd0) &&
                    ((inst_i.i.rs1 == 5'd1) || (inst_i.i.rs1 == 5'd5));

    assign b_imm = {{19{inst_i.b.imm12}}, inst_i.b.imm12, inst_i.b.imm11,
                    inst_i.b.imm10_5, inst_i.b.imm4_1, 1'b0};
    assign j_imm = {{11{inst_i.j.imm20}}, inst_i.j.imm20, inst_i.j.imm19_12,
                    inst_i.j.imm11, inst_i.j.imm10_1, 1'b0};

    assign pc_plus4 = pc_i + `XLEN'd4;

    always_comb begin
        branch_o     = is_branch || is_jal || is_jalr;
        pred_taken_o = 1'b0;
        pred_pc_o    = pc_plus4;
        provider_o   = bpu_pkg::PROV_BIMODAL;

        if (is_ret) begin
            if (!ras_empty_i) begin   // empty stack falls through to pc+4
                pred_taken_o = 1'b1;
                pred_pc_o    = ras_top_i;
            end
        end else if (is_jal) begin
            pred_taken_o = 1'b1;
            pred_pc_o    = btb_hit_i ? btb_target_i : pc_i + j_imm;
        end else if (is_branch || is_jalr) begin
            pred_taken_o = dir_taken_i;
            provider_o   = dir_provider_i;
            if (dir_taken_i) begin
                if (btb_hit_i) begin
                    pred_pc_o = btb_target_i;
                end else if (is_branch) begin
                    pred_pc_o = pc_i + b_imm;
                end
                // jalr without btb entry has no target to offer
            end
        end
    end

endmodule

`default_nettype wire

/* source/bpu_tage.sv */
`timescale 1ns/1ps
`default_nettype none
`include "bpu_macros.svh"

module bpu_tage (
    input  wire                     clk,
    input  wire                     rst,
    input  wire [`XLEN-1:0]         lookup_pc_i,
    output logic                    lookup_taken_o,
    output bpu_pkg::provider_e      lookup_provider_o,
    input  wire                     upd_valid_i,
    input  wire [`XLEN-1:0]         upd_pc_i,
    input  wire                     upd_taken_i,
    input  wire                     upd_correct_i,
    input  wire [`HIST_W-1:0]       upd_history_i,
    input  wire bpu_pkg::provider_e upd_provider_i,
    output logic [`HIST_W-1:0]      history_o
);

    localparam int BIM_IDX_W = $clog2(`BIMODAL_ENTRIES);
    localparam int TIDX_W    = $clog2(`TAGE_ENTRIES);

    logic [1:0]         bimodal  [`BIMODAL_ENTRIES];
    logic [`TAG_W-1:0]  tag_mem  [2][`TAGE_ENTRIES];   // [0] is T0, [1] is T1
    logic [1:0]         ctr_mem  [2][`TAGE_ENTRIES];
    logic [`HIST_W-1:0] ghist_q;

    // short history slice for T0, long slice for T1
    function automatic logic [TIDX_W-1:0] tbl_index(input logic [`XLEN-1:0] pc,
                                                     input logic [`HIST_W-1:0] h,
                                                     input logic long_hist);
        return long_hist ? (pc[TIDX_W-1:0] ^ h[`HIST_W-1 -: TIDX_W])
                         : (pc[TIDX_W-1:0] ^ h[TIDX_W-1:0]);
    endfunction

    function automatic logic [`TAG_W-1:0] tbl_tag(input logic [`XLEN-1:0] pc,
                                                  input logic [`HIST_W-1:0] h,
                                                  input logic long_hist);
        return long_hist ? (pc[TIDX_W +: `TAG_W] ^ {{(`TAG_W-TIDX_W){1'b0}}, h[TIDX_W-1:0]})
                         : (pc[TIDX_W +: `TAG_W] ^ h[`HIST_W-1 -: `TAG_W]);
    endfunction

    function automatic logic [1:0] sat_next(input logic [1:0] c, input logic up);
        if (up) begin
            return (c == 2'b11) ? c : c + 2'b01;
        end
        return (c == 2'b00) ? c : c - 2'b01;
    endfunction

    logic [TIDX_W-1:0]    lk_idx [2];
    logic [`TAG_W-1:0]    lk_tag [2];
    logic [1:0]           lk_hit;
    logic [BIM_IDX_W-1:0] lk_bim_idx;

    logic [TIDX_W-1:0]    up_idx [2];
    logic [`TAG_W-1:0]    up_tag [2];
    logic [1:0]           alloc;
    logic [BIM_IDX_W-1:0] up_bim_idx;
    logic                 bim_miss;

    assign lk_bim_idx = lookup_pc_i[BIM_IDX_W:1];
    assign up_bim_idx = upd_pc_i[BIM_IDX_W:1];

    // the provider came back from execute, so mispredicts by bimodal allocate
    assign bim_miss = upd_valid_i && !upd_correct_i &&
                      (upd_provider_i == bpu_pkg::PROV_BIMODAL);
    assign alloc[1] = bim_miss && (tag_mem[1][up_idx[1]] != up_tag[1]);
    assign alloc[0] = bim_miss && !alloc[1] && (tag_mem[0][up_idx[0]] != up_tag[0]);

    for (genvar g = 0; g < 2; g++) begin : g_tbl
        localparam bpu_pkg::provider_e PROV = (g == 0) ? bpu_pkg::PROV_T0
                                                       : bpu_pkg::PROV_T1;

        assign lk_idx[g] = tbl_index(lookup_pc_i, ghist_q, g[0]);
        assign lk_tag[g] = tbl_tag(lookup_pc_i, ghist_q, g[0]);
        assign lk_hit[g] = (tag_mem[g][lk_idx[g]][`TAG_W-1 -: `PARTIAL_TAG_W] ==
                            lk_tag[g][`TAG_W-1 -: `PARTIAL_TAG_W]);

        assign up_idx[g] = tbl_index(upd_pc_i, upd_history_i, g[0]);
        assign up_tag[g] = tbl_tag(upd_pc_i, upd_history_i, g[0]);

        always_ff @(posedge clk or posedge rst) begin
            if (rst) begin
                for (int k = 0; k < `TAGE_ENTRIES; k++) begin
                    tag_mem[g][k] <= '0;
                    ctr_mem[g][k] <= 2'b01;   // weakly not taken
                end
            end else if (upd_valid_i) begin
                if (alloc[g]) begin
                    tag_mem[g][up_idx[g]] <= up_tag[g];
                    ctr_mem[g][up_idx[g]] <= upd_taken_i ? 2'b10 : 2'b01;
                end else if (upd_provider_i == PROV) begin
                    if (upd_correct_i) begin
                        ctr_mem[g][up_idx[g]] <= sat_next(ctr_mem[g][up_idx[g]], upd_taken_i);
                    end else begin
                        ctr_mem[g][up_idx[g]] <= upd_taken_i ? 2'b11 : 2'b00; // hard reset
                    end
                end
            end
        end
    end

    // longest matching history wins
    always_comb begin
        if (lk_hit[1]) begin
            lookup_taken_o    = ctr_mem[1][lk_idx[1]][1];
            lookup_provider_o = bpu_pkg::PROV_T1;
        end else if (lk_hit[0]) begin
            lookup_taken_o    = ctr_mem[0][lk_idx[0]][1];
            lookup_provider_o = bpu_pkg::PROV_T0;
        end else begin
            lookup_taken_o    = bimodal[lk_bim_idx][1];
            lookup_provider_o = bpu_pkg::PROV_BIMODAL;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int k = 0; k < `BIMODAL_ENTRIES; k++) begin
                bimodal[k] <= 2'b01;
            end
        end else if (upd_valid_i) begin
            bimodal[up_bim_idx] <= sat_next(bimodal[up_bim_idx], upd_taken_i);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ghist_q <= '0;
        end else if (upd_valid_i) begin
            ghist_q <= {ghist_q[`HIST_W-2:0], upd_taken_i}; // newest outcome in bit 0
        end
    end

    assign history_o = ghist_q;

    // returned provider must name one of the three tables
    a_provider_legal: assert property (@(posedge clk) disable iff (rst)
        upd_valid_i |-> upd_provider_i inside {bpu_pkg::PROV_BIMODAL, bpu_pkg::PROV_T0,
                                               bpu_pkg::PROV_T1});

endmodule

`default_nettype wire

/* source/bpu_btb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "bpu_macros.svh"

module bpu_btb (
    input  wire              clk,
    input  wire              rst,
    input  wire [`XLEN-1:0]  lookup_pc_i,
    output logic             hit_o,
    output logic [`XLEN-1:0] target_o,
    input  wire              upd_valid_i,
    input  wire              upd_taken_i,
    input  wire [`XLEN-1:0]  upd_pc_i,
    input  wire [`XLEN-1:0]  upd_target_i
);

    localparam int IDX_W = $clog2(`BTB_ENTRIES);

    logic [`BTB_ENTRIES-1:0] valid_q;
    logic [`BTB_TAG_W-1:0]   tag_mem    [`BTB_ENTRIES];
    logic [`XLEN-1:0]        target_mem [`BTB_ENTRIES];

    logic [IDX_W-1:0]      lk_idx;
    logic [`BTB_TAG_W-1:0] lk_tag;
    logic [IDX_W-1:0]      up_idx;
    logic                  wr_en;

    // word aligned pcs, so bits 1..0 carry nothing
    assign lk_idx = lookup_pc_i[IDX_W+1:2];
    assign lk_tag = lookup_pc_i[`XLEN-1 -: `BTB_TAG_W];
    assign up_idx = upd_pc_i[IDX_W+1:2];
    assign wr_en  = upd_valid_i && upd_taken_i;  // only taken transfers get an entry

    assign hit_o    = valid_q[lk_idx] && (tag_mem[lk_idx] == lk_tag);
    assign target_o = target_mem[lk_idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= '0;
        end else if (wr_en) begin
            valid_q[up_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_mem[up_idx]    <= upd_pc_i[`XLEN-1 -: `BTB_TAG_W];
            target_mem[up_idx] <= upd_target_i;
        end
    end

endmodule

`default_nettype wire

/* source/bpu_ras.sv */
`timescale 1ns/1ps
`default_nettype none
`include "bpu_macros.svh"

module bpu_ras (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 push_i,
    input  wire                 stall_i,
    input  wire [`XLEN-1:0]     push_addr_i,
    input  wire                 pop_valid_i,
    input  wire                 pop_taken_i,
    input  wire bpu_pkg::inst_u pop_inst_i,
    output logic                empty_o,
    output logic [`XLEN-1:0]    top_o
);

    localparam int IDX_W = $clog2(`RAS_DEPTH);

    logic [`XLEN-1:0]      stack_mem [`RAS_DEPTH];
    logic [`RAS_PTR_W-1:0] ptr_q;        // count of live entries
    logic [IDX_W-1:0]      top_idx;
    logic                  full;
    logic                  ret_exec;
    logic                  do_push;
    logic                  do_pop;

    assign empty_o = (ptr_q == '0);
    assign full    = (ptr_q == `RAS_PTR_W'(`RAS_DEPTH));
    assign top_idx = ptr_q[IDX_W-1:0] - 1'b1;
    assign top_o   = stack_mem[top_idx];

    // return seen at execute: jalr through ra or t0
    assign ret_exec = (pop_inst_i.i.opcode == `OPC_JALR) &&
                      ((pop_inst_i.i.rs1 == 5'd1) || (pop_inst_i.i.rs1 == 5'd5));

    assign do_push = push_i && !stall_i && !full;
    assign do_pop  = pop_valid_i && pop_taken_i && ret_exec && !empty_o;

    // push lands at the pointer even when a pop cancels the move
    always_ff @(posedge clk) begin
        if (do_push) begin
            stack_mem[ptr_q[IDX_W-1:0]] <= push_addr_i;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ptr_q <= '0;
        end else begin
            case ({do_push, do_pop})
                2'b10:   ptr_q <= ptr_q + 1'b1;
                2'b01:   ptr_q <= ptr_q - 1'b1;
                default: ptr_q <= ptr_q;   // idle, or push and pop cancel
            endcase
        end
    end

    a_ptr_bounded: assert property (@(posedge clk) disable iff (rst)
        ptr_q <= `RAS_PTR_W'(`RAS_DEPTH));

endmodule

`default_nettype wire

/* source/bpu_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "bpu_macros.svh"

module bpu_top (
    input  wire                     clk,
    input  wire                     rst,
    // fetch
    input  wire [`XLEN-1:0]         if_pc_i,
    input  wire bpu_pkg::inst_u     if_inst_i,
    // decode, call pushes
    input  wire                     ras_push_i,
    input  wire [`XLEN-1:0]         ras_push_addr_i,
    input  wire                     ex_stall_i,
    // execute feedback
    input  wire                     ex_valid_i,
    input  wire                     ex_taken_i,
    input  wire                     ex_correct_i,
    input  wire [`XLEN-1:0]         ex_pc_i,
    input  wire bpu_pkg::inst_u     ex_inst_i,
    input  wire [`XLEN-1:0]         ex_target_i,
    input  wire [`HIST_W-1:0]       ex_history_i,   // history seen at prediction
    input  wire bpu_pkg::provider_e ex_provider_i,  // provider seen at prediction
    // prediction
    output logic                    branch_o,
    output logic                    pred_taken_o,
    output logic [`XLEN-1:0]        pred_pc_o,
    output bpu_pkg::provider_e      provider_o,
    output logic [`HIST_W-1:0]      history_o
);

    logic               dir_taken;
    bpu_pkg::provider_e dir_provider;
    logic               btb_hit;
    logic [`XLEN-1:0]   btb_target;
    logic               ras_empty;
    logic [`XLEN-1:0]   ras_top;

    bpu_tage u_tage (
        .clk               (clk),
        .rst               (rst),
        .lookup_pc_i       (if_pc_i),
        .lookup_taken_o    (dir_taken),
        .lookup_provider_o (dir_provider),
        .upd_valid_i       (ex_valid_i),
        .upd_pc_i          (ex_pc_i),
        .upd_taken_i       (ex_taken_i),
        .upd_correct_i     (ex_correct_i),
        .upd_history_i     (ex_history_i),
        .upd_provider_i    (ex_provider_i),
        .history_o         (history_o)
    );

    bpu_btb u_btb (
        .clk          (clk),
        .rst          (rst),
        .lookup_pc_i  (if_pc_i),
        .hit_o        (btb_hit),
        .target_o     (btb_target),
        .upd_valid_i  (ex_valid_i),
        .upd_taken_i  (ex_taken_i),
        .upd_pc_i     (ex_pc_i),
        .upd_target_i (ex_target_i)
    );

    bpu_ras u_ras (
        .clk         (clk),
        .rst         (rst),
        .push_i      (ras_push_i),
        .stall_i     (ex_stall_i),
        .push_addr_i (ras_push_addr_i),
        .pop_valid_i (ex_valid_i),
        .pop_taken_i (ex_taken_i),
        .pop_inst_i  (ex_inst_i),
        .empty_o     (ras_empty),
        .top_o       (ras_top)
    );

    bpu_decode_select u_select (
        .pc_i           (if_pc_i),
        .inst_i         (if_inst_i),
        .dir_taken_i    (dir_taken),
        .dir_provider_i (dir_provider),
        .btb_hit_i      (btb_hit),
        .btb_target_i   (btb_target),
        .ras_empty_i    (ras_empty),
        .ras_top_i      (ras_top),
        .branch_o       (branch_o),
        .pred_taken_o   (pred_taken_o),
        .pred_pc_o      (pred_pc_o),
        .provider_o     (provider_o)
    );

endmodule

`default_nettype wire

/* sim/bpu_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "bpu_macros.svh"

module bpu_tb;

    localparam int PH_NONCTRL  = 40;
    localparam int PH_JAL      = 24;
    localparam int PH_RAS      = 90;
    localparam int PH_RANDOM   = 2000;
    localparam int CYCLE_LIMIT = (2 + PH_NONCTRL + PH_JAL + PH_RAS + PH_RANDOM) * 3 / 2;
    localparam logic [31:0] NOP    = 32'h0000_0013;
    localparam logic [31:0] RET_RA = 32'h0000_8067;   // jalr x0, 0(ra)
    localparam logic [31:0] RET_T0 = 32'h0002_8067;   // jalr x0, 0(t0)

    logic               clk;
    logic               rst;
    logic [31:0]        if_pc;
    bpu_pkg::inst_u     if_inst;
    logic               ras_push;
    logic [31:0]        ras_push_addr;
    logic               ex_stall;
    logic               ex_valid;
    logic               ex_taken;
    logic               ex_correct;
    logic [31:0]        ex_pc;
    bpu_pkg::inst_u     ex_inst;
    logic [31:0]        ex_target;
    logic [15:0]        ex_history;
    bpu_pkg::provider_e ex_provider;
    logic               branch;
    logic               pred_taken;
    logic [31:0]        pred_pc;
    bpu_pkg::provider_e provider;
    logic [15:0]        history;

    bpu_top dut (
        .clk(clk), .rst(rst), .if_pc_i(if_pc), .if_inst_i(if_inst),
        .ras_push_i(ras_push), .ras_push_addr_i(ras_push_addr), .ex_stall_i(ex_stall),
        .ex_valid_i(ex_valid), .ex_taken_i(ex_taken), .ex_correct_i(ex_correct),
        .ex_pc_i(ex_pc), .ex_inst_i(ex_inst), .ex_target_i(ex_target),
        .ex_history_i(ex_history), .ex_provider_i(ex_provider),
        .branch_o(branch), .pred_taken_o(pred_taken), .pred_pc_o(pred_pc),
        .provider_o(provider), .history_o(history)
    );

    // reference model state
    logic [1:0]            m_bim     [`BIMODAL_ENTRIES];
    logic [`TAG_W-1:0]     m_tag     [2][`TAGE_ENTRIES];   // [0] T0, [1] T1
    logic [1:0]            m_ctr     [2][`TAGE_ENTRIES];
    logic                  m_btb_v   [`BTB_ENTRIES];
    logic [`BTB_TAG_W-1:0] m_btb_tag [`BTB_ENTRIES];
    logic [31:0]           m_btb_tgt [`BTB_ENTRIES];
    logic [31:0]           m_ras     [`RAS_DEPTH];
    int                    m_ras_n;
    logic [15:0]           m_hist;

    logic [31:0] rng = 32'h1392df45;
    int          cycle_count = 0;
    int          check_count = 0;
    int          err_count = 0;
    int          test_err = 0;
    int          hist_err = 0;

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // few distinct pcs so that table entries get reused
    function automatic logic [31:0] pool_pc(input logic [31:0] r);
        return {16'h0001, r[9:8], 6'b000000, r[5:0], 2'b00};
    endfunction

    function automatic logic [31:0] b_offset(input logic [31:0] w);
        return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    endfunction

    function automatic logic [31:0] j_offset(input logic [31:0] w);
        return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    endfunction

    function automatic logic [7:0] table_index(input logic [31:0] pc, input logic [15:0] h,
                                               input logic long_tbl);
        return long_tbl ? (pc[7:0] ^ h[15:8]) : (pc[7:0] ^ h[7:0]);
    endfunction

    function automatic logic [9:0] table_tag(input logic [31:0] pc, input logic [15:0] h,
                                             input logic long_tbl);
        return long_tbl ? (pc[17:8] ^ {2'b00, h[7:0]}) : (pc[17:8] ^ h[15:6]);
    endfunction

    function automatic logic [1:0] saturate(input logic [1:0] c, input logic up);
        if (up) begin
            return (c == 2'd3) ? c : c + 2'd1;
        end
        return (c == 2'd0) ? c : c - 2'd1;
    endfunction

    task automatic reset_model();
        for (int k = 0; k < `BIMODAL_ENTRIES; k++) begin
            m_bim[k] = 2'd1;
        end
        for (int k = 0; k < `TAGE_ENTRIES; k++) begin
            m_tag[0][k] = '0;
            m_tag[1][k] = '0;
            m_ctr[0][k] = 2'd1;
            m_ctr[1][k] = 2'd1;
        end
        for (int k = 0; k < `BTB_ENTRIES; k++) begin
            m_btb_v[k] = 1'b0;
        end
        m_ras_n = 0;
        m_hist  = '0;
    endtask

    task automatic predict_model(input logic [31:0] pc, input logic [31:0] w,
                                 output logic br, output logic taken,
                                 output logic [31:0] npc, output bpu_pkg::provider_e prov);
        logic [7:0] i0;
        logic [7:0] i1;
        logic [9:0] t0;
        logic [9:0] t1;
        logic       dir;
        logic       hit;
        logic       is_ret;
        bpu_pkg::provider_e dprov;
        i0 = table_index(pc, m_hist, 1'b0);
        i1 = table_index(pc, m_hist, 1'b1);
        t0 = table_tag(pc, m_hist, 1'b0);
        t1 = table_tag(pc, m_hist, 1'b1);
        if (m_tag[1][i1][9:4] == t1[9:4]) begin
            dir   = m_ctr[1][i1][1];
            dprov = bpu_pkg::PROV_T1;
        end else if (m_tag[0][i0][9:4] == t0[9:4]) begin
            dir   = m_ctr[0][i0][1];
            dprov = bpu_pkg::PROV_T0;
        end else begin
            dir   = m_bim[pc[9:1]][1];
            dprov = bpu_pkg::PROV_BIMODAL;
        end
        hit    = m_btb_v[pc[9:2]] && (m_btb_tag[pc[9:2]] == pc[31:10]);
        is_ret = (w[6:0] == `OPC_JALR) && (w[11:7] == 5'd0) && (w[31:20] == 12'd0) &&
                 ((w[19:15] == 5'd1) || (w[19:15] == 5'd5));
        br    = (w[6:0] == `OPC_BRANCH) || (w[6:0] == `OPC_JAL) || (w[6:0] == `OPC_JALR);
        taken = 1'b0;
        npc   = pc + 32'd4;
        prov  = bpu_pkg::PROV_BIMODAL;
        if (is_ret) begin
            if (m_ras_n > 0) begin
                taken = 1'b1;
                npc   = m_ras[m_ras_n-1];
            end
        end else if (w[6:0] == `OPC_JAL) begin
            taken = 1'b1;
            npc   = hit ? m_btb_tgt[pc[9:2]] : pc + j_offset(w);
        end else if (br) begin
            taken = dir;
            prov  = dprov;
            if (dir && hit) begin
                npc = m_btb_tgt[pc[9:2]];
            end else if (dir && w[6:0] == `OPC_BRANCH) begin
                npc = pc + b_offset(w);
            end
        end
    endtask

    // state change at the clock edge that ends the current cycle
    task automatic update_model(input logic [31:0] pc, input logic [31:0] w,
                                input logic fb_valid, input logic taken, input logic correct,
                                input logic [31:0] target, input logic [15:0] h,
                                input bpu_pkg::provider_e prov,
                                input logic push, input logic [31:0] push_addr);
        logic [7:0] i0;
        logic [7:0] i1;
        logic [9:0] t0;
        logic [9:0] t1;
        logic       do_push;
        logic       do_pop;
        do_push = push && (m_ras_n < `RAS_DEPTH);
        do_pop  = fb_valid && taken && (w[6:0] == `OPC_JALR) && (m_ras_n > 0) &&
                  ((w[19:15] == 5'd1) || (w[19:15] == 5'd5));
        if (do_push) begin
            m_ras[m_ras_n] = push_addr;
        end
        if (do_push && !do_pop) begin
            m_ras_n++;
        end else if (do_pop && !do_push) begin
            m_ras_n--;
        end
        if (fb_valid) begin
            i0 = table_index(pc, h, 1'b0);
            i1 = table_index(pc, h, 1'b1);
            t0 = table_tag(pc, h, 1'b0);
            t1 = table_tag(pc, h, 1'b1);
            m_hist          = {m_hist[14:0], taken};
            m_bim[pc[9:1]]  = saturate(m_bim[pc[9:1]], taken);
            if (!correct && prov == bpu_pkg::PROV_T1) begin
                m_ctr[1][i1] = taken ? 2'd3 : 2'd0;
            end else if (!correct && prov == bpu_pkg::PROV_T0) begin
                m_ctr[0][i0] = taken ? 2'd3 : 2'd0;
            end else if (!correct && m_tag[1][i1] != t1) begin
                m_tag[1][i1] = t1;
                m_ctr[1][i1] = taken ? 2'd2 : 2'd1;
            end else if (!correct && m_tag[0][i0] != t0) begin
                m_tag[0][i0] = t0;
                m_ctr[0][i0] = taken ? 2'd2 : 2'd1;
            end else if (correct && prov == bpu_pkg::PROV_T1) begin
                m_ctr[1][i1] = saturate(m_ctr[1][i1], taken);
            end else if (correct && prov == bpu_pkg::PROV_T0) begin
                m_ctr[0][i0] = saturate(m_ctr[0][i0], taken);
            end
            if (taken) begin
                m_btb_v[pc[9:2]]   = 1'b1;
                m_btb_tag[pc[9:2]] = pc[31:10];
                m_btb_tgt[pc[9:2]] = target;
            end
        end
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] pc,
                                   input logic [31:0] exp, input logic [31:0] got);
        $display("MISMATCH %s at pc %h: expected %h, got %h", name, pc, exp, got);
        err_count++;
        test_err++;
    endtask

    // one fetch, and optionally execute feedback for that same instruction
    task automatic run_cycle(input logic [31:0] pc, input logic [31:0] w,
                             input logic fb_valid, input logic fb_taken,
                             input logic [31:0] fb_target, input logic push,
                             input logic stall, input logic [31:0] push_addr);
        logic               e_br;
        logic               e_taken;
        logic [31:0]        e_pc;
        logic [15:0]        e_hist;
        bpu_pkg::provider_e e_prov;
        predict_model(pc, w, e_br, e_taken, e_pc, e_prov);
        e_hist = m_hist;
        @(posedge clk);
        if_pc         <= pc;
        if_inst       <= w;
        ras_push      <= push;
        ras_push_addr <= push_addr;
        ex_stall      <= stall;
        ex_valid      <= fb_valid;
        ex_taken      <= fb_taken;
        ex_correct    <= (fb_taken == e_taken);
        ex_pc         <= pc;
        ex_inst       <= w;
        ex_target     <= fb_target;
        ex_history    <= e_hist;
        ex_provider   <= e_prov;
        @(negedge clk);   // outputs settled
        check_count++;
        if (branch !== e_br) begin
            report_mismatch("branch_o", pc, 32'(e_br), 32'(branch));
        end
        if (pred_taken !== e_taken) begin
            report_mismatch("pred_taken_o", pc, 32'(e_taken), 32'(pred_taken));
        end
        if (pred_pc !== e_pc) begin
            report_mismatch("pred_pc_o", pc, e_pc, pred_pc);
        end
        if (provider !== e_prov) begin
            report_mismatch("provider_o", pc, 32'(e_prov), 32'(provider));
        end
        if (history !== e_hist) begin
            report_mismatch("history_o", pc, 32'(e_hist), 32'(history));
            hist_err++;
        end
        update_model(pc, w, fb_valid, fb_taken, fb_taken == e_taken, fb_target, e_hist,
                     e_prov, push && !stall, push_addr);
    endtask

    task automatic finish_test(input string name);
        if (test_err == 0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, test_err);
        end
        test_err = 0;
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] w;
        logic [31:0] pc;
        clk           = 1'b0;
        rst           = 1'b1;
        if_pc         = '0;
        if_inst       = '0;
        ras_push      = 1'b0;
        ras_push_addr = '0;
        ex_stall      = 1'b0;
        ex_valid      = 1'b0;
        ex_taken      = 1'b0;
        ex_correct    = 1'b0;
        ex_pc         = '0;
        ex_inst       = '0;
        ex_target     = '0;
        ex_history    = '0;
        ex_provider   = bpu_pkg::PROV_BIMODAL;
        reset_model();
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        for (int n = 0; n < PH_NONCTRL; n++) begin
            r = xorshift32();
            w = xorshift32();
            if (w[6:0] inside {`OPC_BRANCH, `OPC_JAL, `OPC_JALR}) begin
                w[6:0] = 7'b0110011;   // plain alu op
            end
            run_cycle(pool_pc(r), w, 1'b0, 1'b0, '0, 1'b0, 1'b0, '0);
        end
        finish_test("1 non-control");

        // miss, taken feedback, then hit on the written target
        for (int n = 0; n < PH_JAL / 3; n++) begin
            pc = 32'h0000_4000 + (32'(n) << 6);
            r  = xorshift32();
            w  = {r[31:7], `OPC_JAL};
            r  = xorshift32();
            run_cycle(pc, w, 1'b0, 1'b0, '0, 1'b0, 1'b0, '0);
            run_cycle(pc, w, 1'b1, 1'b1, {r[31:2], 2'b00}, 1'b0, 1'b0, '0);
            run_cycle(pc, w, 1'b0, 1'b0, '0, 1'b0, 1'b0, '0);
        end
        finish_test("2 jal and btb");

        for (int n = 0; n < 6; n++) begin
            r = xorshift32();
            run_cycle(32'h0000_6000, NOP, 1'b0, 1'b0, '0, 1'b1, n == 3, {r[31:2], 2'b00});
        end
        for (int n = 0; n < 6; n++) begin   // last one hits an empty stack
            run_cycle(32'h0000_6100 + (32'(n) << 2), n[0] ? RET_T0 : RET_RA,
                      1'b1, 1'b1, 32'h0000_7000, 1'b0, 1'b0, '0);
        end
        for (int n = 0; n < `RAS_DEPTH + 2; n++) begin
            r = xorshift32();
            run_cycle(32'h0000_6200, NOP, 1'b0, 1'b0, '0, 1'b1, 1'b0, {r[31:2], 2'b00});
        end
        run_cycle(32'h0000_6300, RET_RA, 1'b0, 1'b0, '0, 1'b0, 1'b0, '0);
        for (int n = 0; n < `RAS_DEPTH + 1; n++) begin
            r = xorshift32();
            run_cycle(32'h0000_6400, n[0] ? RET_T0 : RET_RA, 1'b1, 1'b1, 32'h0000_7000,
                      n == 1, 1'b0, {r[31:2], 2'b00});   // one push meets a pop
        end
        finish_test("3 return stack");

        for (int n = 0; n < PH_RANDOM; n++) begin
            r  = xorshift32();
            w  = xorshift32();
            w[6:0] = `OPC_BRANCH;
            pc = pool_pc(r);
            // outcome biased per pc so the counters learn something
            run_cycle(pc, w, r[20:19] != 2'b00,
                      pc[4] ? (r[18:16] != 3'd0) : (r[18:16] == 3'd0),
                      pc + b_offset(w), 1'b0, 1'b0, '0);
        end
        finish_test("4 random branches");

        test_err = hist_err;
        finish_test("5 global history");

        $display("checks: %0d, errors: %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* bpu.f */
+incdir+source
source/bpu_pkg.sv
source/bpu_decode_select.sv
source/bpu_tage.sv
source/bpu_btb.sv
source/bpu_ras.sv
source/bpu_top.sv
sim/bpu_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module bpu_tb -f bpu.f \
    -Mdir obj_dir -o bpu_sim
./obj_dir/bpu_sim > sim.log
cat sim.log

if grep -qx "RESULT: PASS" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
